/* all.f */
+incdir+verification
design/filter_pkg.sv
design/test_config_regs.sv
design/pulse_timer.sv
design/exp_sig_gen.sv
design/v1_filter.sv
design/filter.sv
verification/filter_tb.sv

/* design/exp_sig_gen.sv */
//--------------------
// Exponential test pulse generator on a fixed baseline
// Decay by shift and subtract, no waveform tables
// Overlay stacks pulses, saturating at full scale
// Output lags the pulse value by one clock
//--------------------
`timescale 1ns/1ps

module exp_sig_gen (
	input  logic                     clk,
	input  logic                     reset,
	input  filter_pkg::test_config_t cfg,
	output filter_pkg::adc_data_t    output_data
);
	import filter_pkg::*;

	// Pulse start from the timer
	logic fire;
	// Height above baseline
	adc_data_t pulse;
	// Old tail plus a new pulse, one bit of headroom
	logic [SIZE_ADC_DATA:0] stacked;
	// Baseline plus pulse, one bit of headroom
	logic [SIZE_ADC_DATA:0] level;

	//--------------------
	// Timer
	//--------------------
	pulse_timer timer (
		.clk   (clk),
		.reset (reset),
		.rate  (cfg.rate),
		.delay (cfg.delay),
		.fire  (fire)
	);

	//--------------------
	// Pulse value
	//--------------------
	assign stacked = {1'b0, pulse} + (SIZE_ADC_DATA + 1)'(PULSE_AMPLITUDE);

	always_ff @(posedge clk) begin
		if (reset) begin
			pulse <= '0;
		end else if (fire) begin
			if (!cfg.overlay) begin
				// Replace whatever tail is left
				pulse <= adc_data_t'(PULSE_AMPLITUDE);
			end else if (stacked > (SIZE_ADC_DATA + 1)'(PULSE_MAX)) begin
				// Top out so baseline plus pulse stays in range
				pulse <= adc_data_t'(PULSE_MAX);
			end else begin
				pulse <= stacked[SIZE_ADC_DATA-1:0];
			end
		end else begin
			// Lose one eighth per clock
			pulse <= pulse - (pulse >> DECAY_SHIFT);
		end
	end

	//--------------------
	// Output sample
	//--------------------
	assign level = {1'b0, pulse} + (SIZE_ADC_DATA + 1)'(BASELINE);

	always_ff @(posedge clk) begin
		if (reset) begin
			output_data <= adc_data_t'(BASELINE);
		end else if (level > (SIZE_ADC_DATA + 1)'(ADC_MAX)) begin
			output_data <= adc_data_t'(ADC_MAX);
		end else begin
			output_data <= level[SIZE_ADC_DATA-1:0];
		end
	end

	// Decay and saturation must never eat into the baseline
	assert property (@(posedge clk) disable iff (reset)
		output_data >= adc_data_t'(BASELINE));

endmodule

/* design/filter.sv */
//--------------------
// Test channel top level
// Config registers feed the generator, generator feeds filter v1
// Only filter version 1 is built
//--------------------
`timescale 1ns/1ps

module filter (
	input  logic                     clk,
	input  logic                     reset,
	//--------------------
	// Configuration write
	//--------------------
	input  logic                     cfg_write,
	input  filter_pkg::test_config_t cfg_data,
	//--------------------
	// Samples out
	//--------------------
	output filter_pkg::adc_data_t    output_data,
	output filter_pkg::filter_data_t output_data_v1
);
	import filter_pkg::*;

	// Held generator settings
	test_config_t cfg;

	test_config_regs config_regs (
		.clk       (clk),
		.reset     (reset),
		.cfg_write (cfg_write),
		.cfg_data  (cfg_data),
		.cfg       (cfg)
	);

	// Generator sample goes straight out as well as into the filter
	exp_sig_gen sig_gen (
		.clk         (clk),
		.reset       (reset),
		.cfg         (cfg),
		.output_data (output_data)
	);

	v1_filter filter_v1 (
		.clk         (clk),
		.reset       (reset),
		.input_data  (output_data),
		.output_data (output_data_v1)
	);

endmodule

/* design/filter_pkg.sv */
//--------------------
// Shared widths, timing constants and types of the test channel
// Periods must not exceed 2**SIZE_DELAY clocks
// Filter width holds FILTER_WINDOW full-scale samples
//--------------------
package filter_pkg;

	//--------------------
	// Widths
	//--------------------
	localparam int SIZE_ADC_DATA    = 12;
	localparam int SIZE_FILTER_DATA = 15;
	localparam int SIZE_DELAY       = 6;

	// Sample and sum types
	typedef logic [SIZE_ADC_DATA-1:0]    adc_data_t;
	typedef logic [SIZE_FILTER_DATA-1:0] filter_data_t;
	// Pulse delay inside a period, in clocks
	typedef logic [SIZE_DELAY-1:0]       delay_t;

	//--------------------
	// Generator timing
	//--------------------
	// Period for rate 0 and rate 1
	localparam int PERIOD_SLOW = 64;
	localparam int PERIOD_FAST = 16;
	// Last counter value of each period
	localparam delay_t LAST_SLOW = delay_t'(PERIOD_SLOW - 1);
	localparam delay_t LAST_FAST = delay_t'(PERIOD_FAST - 1);

	// Pulse shape
	localparam int BASELINE        = 256;
	localparam int PULSE_AMPLITUDE = 1500;
	localparam int DECAY_SHIFT     = 3;
	// Full scale of a sample, and the highest pulse that stays inside it
	localparam int ADC_MAX   = 2 ** SIZE_ADC_DATA - 1;
	localparam int PULSE_MAX = ADC_MAX - BASELINE;

	// Samples summed by the shaping filter
	localparam int FILTER_WINDOW = 8;

	// Generator settings, written as one word
	typedef struct packed {
		logic   overlay;
		logic   rate;
		delay_t delay;
	} test_config_t;

endpackage

/* design/pulse_timer.sv */
//--------------------
// Free-running period counter with a registered fire strobe
// Period picked by rate, strobe one clock wide
// A rate change past the new limit wraps at the next edge
//--------------------
`timescale 1ns/1ps

module pulse_timer (
	input  logic               clk,
	input  logic               reset,
	input  logic               rate,
	input  filter_pkg::delay_t delay,
	output logic               fire
);
	import filter_pkg::*;

	// Position inside the current period
	delay_t count;
	// Last count of the selected period
	delay_t count_last;

	assign count_last = rate ? LAST_FAST : LAST_SLOW;

	//--------------------
	// Counter
	//--------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (count >= count_last) begin
			// Also catches a count left past a shorter period
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	//--------------------
	// Fire strobe
	//--------------------
	// High for the clock after the count meets the delay
	always_ff @(posedge clk) begin
		if (reset) begin
			fire <= 1'b0;
		end else begin
			fire <= (count == delay);
		end
	end

	// No back-to-back strikes unless the delay was just rewritten
	assert property (@(posedge clk) disable iff (reset)
		fire && $stable(delay) |=> !fire);

endmodule

/* design/test_config_regs.sv */
//--------------------
// Generator configuration registers
// Loaded on a one-cycle write strobe, no read back
// Delay is clamped to the period of the written rate
//--------------------
`timescale 1ns/1ps

module test_config_regs (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cfg_write,
	input  filter_pkg::test_config_t cfg_data,
	output filter_pkg::test_config_t cfg
);
	import filter_pkg::*;

	// Highest reachable delay for the written rate
	delay_t delay_limit;
	// Written word with the delay clamped
	test_config_t cfg_clamped;

	//--------------------
	// Clamp
	//--------------------
	always_comb begin
		delay_limit = cfg_data.rate ? LAST_FAST : LAST_SLOW;
		cfg_clamped = cfg_data;
		// Delay past the period would never fire
		if (cfg_data.delay > delay_limit) begin
			cfg_clamped.delay = delay_limit;
		end
	end

	//--------------------
	// Register
	//--------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			// Overlay off, slow rate, delay 0
			cfg <= '0;
		end else if (cfg_write) begin
			cfg <= cfg_clamped;
		end
	end

	// Timer must always see a delay inside its period
	assert property (@(posedge clk) disable iff (reset)
		cfg.delay < (cfg.rate ? PERIOD_FAST : PERIOD_SLOW));

endmodule

/* design/v1_filter.sv */
//--------------------
// Shaping filter version 1, moving-window sum
// Window of FILTER_WINDOW samples, one sample per clock
// Sum lags the newest sample by one clock
//--------------------
`timescale 1ns/1ps

module v1_filter (
	input  logic                     clk,
	input  logic                     reset,
	input  filter_pkg::adc_data_t    input_data,
	output filter_pkg::filter_data_t output_data
);
	import filter_pkg::*;

	// Newest sample at index 0
	adc_data_t window [FILTER_WINDOW];
	// Sum after this clock's shift
	filter_data_t sum_next;

	//--------------------
	// Window
	//--------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			// Empty window keeps the running sum consistent
			for (int i = 0; i < FILTER_WINDOW; i++) begin
				window[i] <= '0;
			end
		end else begin
			window[0] <= input_data;
			for (int i = 1; i < FILTER_WINDOW; i++) begin
				window[i] <= window[i-1];
			end
		end
	end

	//--------------------
	// Running sum
	//--------------------
	// Add the sample coming in, drop the one falling out
	assign sum_next = output_data
		+ filter_data_t'(input_data)
		- filter_data_t'(window[FILTER_WINDOW-1]);

	always_ff @(posedge clk) begin
		if (reset) begin
			output_data <= '0;
		end else begin
			output_data <= sum_next;
		end
	end

	// Sum must stay within a window of full-scale samples
	assert property (@(posedge clk) disable iff (reset)
		output_data <= filter_data_t'(FILTER_WINDOW * ADC_MAX));

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the test channel testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f \
	--top-module filter_tb -o filter_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output="$(./obj_dir/filter_sim 2>&1)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "all tests passed"; then
	exit 0
fi
exit 1

/* verification/filter_model.svh */
//--------------------
// Cycle model of the config clamp, pulse timer, generator and filter v1
// Included inside the testbench module, after the package import
// Call advance_model once per rising edge with the inputs seen there
//--------------------
`ifndef FILTER_MODEL_SVH
`define FILTER_MODEL_SVH

// Model state, one variable per DUT register it tracks
test_config_t exp_cfg;
int           exp_count;
bit           exp_fire;
int           exp_pulse;
int           exp_sample;
int           exp_window [FILTER_WINDOW];
int           exp_sum;

task automatic reset_model();
	int i;
	exp_cfg    = '0;
	exp_count  = 0;
	exp_fire   = 1'b0;
	exp_pulse  = 0;
	exp_sample = BASELINE;
	exp_sum    = 0;
	for (i = 0; i < FILTER_WINDOW; i++) begin
		exp_window[i] = 0;
	end
endtask

task automatic advance_model(input logic rst, input logic wr, input test_config_t data);
	test_config_t next_cfg;
	int           full_scale;
	int           limit;
	int           next_count;
	bit           next_fire;
	int           next_pulse;
	int           i;
	full_scale = (1 << SIZE_ADC_DATA) - 1;
	if (rst) begin
		reset_model();
	end else begin
		// Register load, delay held below the written period
		next_cfg = exp_cfg;
		if (wr) begin
			next_cfg = data;
			limit = data.rate ? PERIOD_FAST : PERIOD_SLOW;
			if (int'(data.delay) >= limit) begin
				next_cfg.delay = delay_t'(limit - 1);
			end
		end
		// Counter wraps at the end of the current period
		limit = exp_cfg.rate ? PERIOD_FAST : PERIOD_SLOW;
		next_count = (exp_count + 1 >= limit) ? 0 : exp_count + 1;
		next_fire = (exp_count == int'(exp_cfg.delay));
		// Pulse load on a strike, else lose one eighth
		if (!exp_fire) begin
			next_pulse = exp_pulse - (exp_pulse >> DECAY_SHIFT);
		end else if (exp_cfg.overlay) begin
			next_pulse = exp_pulse + PULSE_AMPLITUDE;
			if (next_pulse > full_scale - BASELINE) begin
				next_pulse = full_scale - BASELINE;
			end
		end else begin
			next_pulse = PULSE_AMPLITUDE;
		end
		// Window takes the sample as it stood before this edge
		for (i = FILTER_WINDOW - 1; i > 0; i--) begin
			exp_window[i] = exp_window[i-1];
		end
		exp_window[0] = exp_sample;
		exp_sum = 0;
		for (i = 0; i < FILTER_WINDOW; i++) begin
			exp_sum += exp_window[i];
		end
		// New sample from the old pulse value
		exp_sample = BASELINE + exp_pulse;
		if (exp_sample > full_scale) begin
			exp_sample = full_scale;
		end
		exp_pulse = next_pulse;
		exp_fire  = next_fire;
		exp_count = next_count;
		exp_cfg   = next_cfg;
	end
endtask

`endif

/* verification/filter_tb.sv */
//--------------------
// Testbench for the test channel top level
// Random config writes from a fixed seed, model compared every clock
// Outputs sampled on the falling edge, stops at the first error
//--------------------
`timescale 1ns/1ps

module filter_tb;
	import filter_pkg::*;

	//--------------------
	// DUT signals
	//--------------------
	logic         clk;
	logic         reset;
	logic         cfg_write;
	test_config_t cfg_data;
	adc_data_t    output_data;
	filter_data_t output_data_v1;

	// Random stream state
	integer seed;

	`include "filter_model.svh"

	filter UUT (
		.clk            (clk),
		.reset          (reset),
		.cfg_write      (cfg_write),
		.cfg_data       (cfg_data),
		.output_data    (output_data),
		.output_data_v1 (output_data_v1)
	);

	// 40 ns period
	always #20 clk = ~clk;

	//--------------------
	// Checks
	//--------------------
	task automatic report_failure(input string reason);
		$display("%s", reason);
		$display("tests failed");
		$fatal(1, "run stopped at %0t ns", $time);
	endtask

	task automatic check_sample(input string name, input adc_data_t actual,
		input adc_data_t expected);
		if (actual !== expected) begin
			report_failure($sformatf("MISMATCH at %0t ns: %s is %0d, expected %0d",
				$time, name, actual, expected));
		end
	endtask

	task automatic check_sum(input string name, input filter_data_t actual,
		input filter_data_t expected);
		if (actual !== expected) begin
			report_failure($sformatf("MISMATCH at %0t ns: %s is %0d, expected %0d",
				$time, name, actual, expected));
		end
	endtask

	//--------------------
	// Stimulus
	//--------------------
	// One clock: step the model, drive the next inputs, compare mid-cycle
	task automatic run_cycle(input logic rst, input logic wr, input test_config_t data);
		@(posedge clk);
		advance_model(reset, cfg_write, cfg_data);
		reset     <= rst;
		cfg_write <= wr;
		cfg_data  <= data;
		@(negedge clk);
		check_sample("output_data", output_data, adc_data_t'(exp_sample));
		check_sum("output_data_v1", output_data_v1, filter_data_t'(exp_sum));
	endtask

	task automatic random_cycle();
		logic [31:0]  rnd;
		test_config_t data;
		rnd  = $random(seed);
		data = rnd[SIZE_DELAY+1:0];
		// Roughly one write in 32 clocks, delays past the period included
		run_cycle(1'b0, rnd[31:27] == 5'd0, data);
	endtask

	task automatic wait_for_sample(input adc_data_t target, input int limit,
		input string what);
		int waited;
		waited = 0;
		while (output_data !== target) begin
			if (waited >= limit) begin
				report_failure($sformatf("timeout after %0d clocks waiting for %s",
					limit, what));
			end else begin
				run_cycle(1'b0, 1'b0, cfg_data);
				waited++;
			end
		end
	endtask

	//--------------------
	// Main sequence
	//--------------------
	initial begin
		int           i;
		int           waited;
		test_config_t data;
		seed      = 32'hc7eaa62b;
		clk       = 1'b0;
		reset     = 1'b1;
		cfg_write = 1'b0;
		cfg_data  = '0;
		reset_model();

		// Reset seen by 10 edges
		for (i = 0; i < 10; i++) begin
			run_cycle(i < 9, 1'b0, '0);
		end
		check_sample("output_data", output_data, adc_data_t'(BASELINE));
		check_sum("output_data_v1", output_data_v1, '0);

		for (i = 0; i < 3000; i++) begin
			random_cycle();
		end

		// Single pulse peak, slow rate, last delay of the period
		data         = '0;
		data.delay   = delay_t'(PERIOD_SLOW - 1);
		run_cycle(1'b0, 1'b1, data);
		wait_for_sample(adc_data_t'(BASELINE + PULSE_AMPLITUDE), 2 * PERIOD_SLOW + 4,
			"a slow-rate pulse peak");

		// Fast rate with a delay that only fires once clamped
		data.rate  = 1'b1;
		data.delay = delay_t'(40);
		run_cycle(1'b0, 1'b1, data);
		wait_for_sample(adc_data_t'(BASELINE + PULSE_AMPLITUDE), 2 * PERIOD_FAST + 4,
			"a pulse at the clamped delay");

		// Move the delay ahead of the counter each clock so pulses stack
		waited       = 0;
		data.overlay = 1'b1;
		data.rate    = 1'b1;
		while (output_data !== adc_data_t'((1 << SIZE_ADC_DATA) - 1)) begin
			if (waited >= 200) begin
				report_failure("stacked pulses never reached full scale");
			end else begin
				data.delay = delay_t'((exp_count + 2) % PERIOD_FAST);
				run_cycle(1'b0, 1'b1, data);
				waited++;
			end
		end

		for (i = 0; i < 3000; i++) begin
			random_cycle();
		end

		$display("all tests passed");
		$finish;
	end

endmodule
